// File: common/adder_macros.svh
// Adder width macros
`ifndef ADDER_MACROS_SVH
`define ADDER_MACROS_SVH

// Operand and sum width in bits
`define ADDER_WIDTH 22

// Number of opcodes, sets the opcode field width
`define ADDER_OP_COUNT 4

`endif

// File: common/adder_op_pkg.sv
// Adder request types
`include "adder_macros.svh"

package adder_op_pkg;

	// One operand or sum word
	typedef logic [`ADDER_WIDTH-1:0] adder_word_t;

	// Accumulate forms take the accumulator in place of operand a
	typedef enum logic [$clog2(`ADDER_OP_COUNT)-1:0] {
		op_add     = 2'd0,
		op_sub     = 2'd1,
		op_acc_add = 2'd2,
		op_acc_sub = 2'd3
	} adder_opcode_t;

	// Strobed request as seen at the unit input
	typedef struct packed {
		adder_opcode_t opcode;
		adder_word_t   a;
		adder_word_t   b;
	} adder_request_t;

endpackage

// File: common/adder_result_pkg.sv
// Adder result types
`include "adder_macros.svh"

package adder_result_pkg;

	import adder_op_pkg::*;

	// Status of one registered sum
	typedef struct packed {
		logic carry;
		logic overflow;
		logic zero;
	} adder_flags_t;

	// Sum word with its flags
	typedef struct packed {
		adder_word_t  sum;
		adder_flags_t flags;
	} adder_result_t;

endpackage

// File: hw/prefix_adder/ling_prefix_adder.sv
// Sparse Ling prefix adder
`timescale 1ns/100ps
`include "adder_macros.svh"

module ling_prefix_adder
	import adder_op_pkg::*;
(
	input  adder_word_t a,
	input  adder_word_t b,
	input  logic        carry_in,
	output adder_word_t sum,
	output logic        carry_out
);

	localparam int ADD_W = `ADDER_WIDTH;
	// Tree nodes sit on odd positions 1, 3, ... ADD_W-1
	localparam int ODD_NODES = ADD_W / 2;
	localparam int TREE_STAGES = $clog2(ADD_W);

	// Position 0 is the carry in, positions 1..ADD_W are operand bits 0..ADD_W-1
	wire [ADD_W:1] t;
	wire [ADD_W:0] g;

	// Ling pseudo-carries H(j:0) and real carries into each position
	wire [ADD_W:1] h;
	wire [ADD_W:1] c;

	// Node k of a stage stands for position 2k+1
	wire [TREE_STAGES:1][ODD_NODES-1:0] node_h;
	wire [TREE_STAGES:1][ODD_NODES-1:0] node_i;

	genvar s, k, j;

	// Pre-computation
	assign t = a | b;
	assign g = {a & b, carry_in};

	// First stage of reduced cells spanning two positions
	for (k = 0; k < ODD_NODES; k++) begin : g_stage1
		if (k == 0) begin : g_rgrey
			// Reaches position 0 already
			assign node_h[1][k] = g[1] | g[0];
		end else begin : g_rblack
			assign node_h[1][k] = g[2*k+1] | g[2*k];
			assign node_i[1][k] = t[2*k] & t[2*k-1];
		end
	end

	// Later stages double the span each time
	for (s = 2; s <= TREE_STAGES; s++) begin : g_stage
		localparam int DIST = 1 << (s - 2);

		for (k = 0; k < ODD_NODES; k++) begin : g_node
			if (k < DIST) begin : g_pass
				// Prefix to position 0 finished in an earlier stage
				assign node_h[s][k] = node_h[s-1][k];
			end else if (k < 2 * DIST) begin : g_grey
				assign node_h[s][k] = node_h[s-1][k] |
					(node_i[s-1][k] & node_h[s-1][k-DIST]);
			end else begin : g_black
				assign node_h[s][k] = node_h[s-1][k] |
					(node_i[s-1][k] & node_h[s-1][k-DIST]);
				assign node_i[s][k] = node_i[s-1][k] & node_i[s-1][k-DIST];
			end
		end
	end

	// Odd positions from the tree and even positions from one extra grey cell
	for (k = 0; k < ODD_NODES; k++) begin : g_fill
		assign h[2*k+1] = node_h[TREE_STAGES][k];

		if (k > 0) begin : g_even
			assign h[2*k] = g[2*k] | (t[2*k-1] & node_h[TREE_STAGES][k-1]);
		end
	end

	// Real carry is t AND H one position down
	assign c[1] = g[0];

	for (j = 1; j < ADD_W; j++) begin : g_carry
		assign c[j+1] = t[j] & h[j];
	end

	// Top position is outside the tree
	assign h[ADD_W] = g[ADD_W] | c[ADD_W];

	// H(j:0) is g(j) OR c(j), so the XOR drops the carry when both bits are set
	for (j = 1; j <= ADD_W; j++) begin : g_sum
		assign sum[j-1] = (t[j] ^ h[j]) | (g[j] & c[j]);
	end

	assign carry_out = t[ADD_W] & h[ADD_W];

endmodule

// File: hw/operand_stage.sv
// Adder operand stage
`timescale 1ns/100ps
`include "adder_macros.svh"

module operand_stage
	import adder_op_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           in_valid,
	input  adder_request_t request,
	input  adder_word_t    accumulator,
	output logic           stage_valid,
	output adder_word_t    eff_a,
	output adder_word_t    eff_b,
	output logic           carry_in,
	output logic           sign_a,
	output logic           sign_b
);

	adder_request_t req_q;
	logic           use_acc;
	logic           invert_b;

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			req_q <= request;
		end
	end

	// Opcode decode
	always_comb begin
		use_acc  = 1'b0;
		invert_b = 1'b0;
		case (req_q.opcode)
			op_sub: begin
				invert_b = 1'b1;
			end
			op_acc_add: begin
				use_acc = 1'b1;
			end
			op_acc_sub: begin
				use_acc  = 1'b1;
				invert_b = 1'b1;
			end
			default: begin
				use_acc  = 1'b0;
				invert_b = 1'b0;
			end
		endcase
	end

	// accumulator here already holds the previous request's sum
	assign eff_a    = use_acc ? accumulator : req_q.a;
	assign eff_b    = invert_b ? ~req_q.b : req_q.b;
	assign carry_in = invert_b;

	assign sign_a = eff_a[`ADDER_WIDTH-1];
	assign sign_b = eff_b[`ADDER_WIDTH-1];

	a_opcode_known: assert property (@(posedge clk) disable iff (reset)
		stage_valid |-> !$isunknown(req_q.opcode));

endmodule

// File: hw/result_stage.sv
// Adder result stage
`timescale 1ns/100ps
`include "adder_macros.svh"

module result_stage
	import adder_op_pkg::*;
	import adder_result_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          stage_valid,
	input  adder_word_t   sum,
	input  logic          carry_out,
	input  logic          sign_a,
	input  logic          sign_b,
	output logic          out_valid,
	output adder_result_t result,
	output adder_word_t   accumulator
);

	adder_flags_t flags_d;

	// Flags from the combinational sum
	always_comb begin
		flags_d.carry    = carry_out;
		// Like signs in, other sign out
		flags_d.overflow = (sign_a == sign_b) && (sum[`ADDER_WIDTH-1] != sign_a);
		flags_d.zero     = (sum == '0);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid   <= 1'b0;
			accumulator <= '0;
		end else begin
			out_valid <= stage_valid;
			if (stage_valid) begin
				accumulator <= sum;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stage_valid) begin
			result.sum   <= sum;
			result.flags <= flags_d;
		end
	end

	// Accumulator holds the sum of every valid result
	a_acc_loaded: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (accumulator == result.sum));

	// Overflow to a positive sum needs two negative operands, which always carry out
	a_overflow_carry: assert property (@(posedge clk) disable iff (reset)
		(out_valid && result.flags.overflow && !result.sum[`ADDER_WIDTH-1])
		|-> result.flags.carry);

endmodule

// File: hw/adder_unit_top.sv
// Adder unit top level
`timescale 1ns/100ps

module adder_unit_top
	import adder_op_pkg::*;
	import adder_result_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           in_valid,
	input  adder_request_t request,
	output logic           out_valid,
	output adder_result_t  result,
	output adder_word_t    accumulator
);

	logic        stage_valid;
	adder_word_t eff_a;
	adder_word_t eff_b;
	logic        carry_in;
	logic        sign_a;
	logic        sign_b;
	adder_word_t sum;
	logic        carry_out;

	operand_stage u_operand (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.request     (request),
		.accumulator (accumulator),
		.stage_valid (stage_valid),
		.eff_a       (eff_a),
		.eff_b       (eff_b),
		.carry_in    (carry_in),
		.sign_a      (sign_a),
		.sign_b      (sign_b)
	);

	// Combinational, same cycle as the operand stage
	ling_prefix_adder u_adder (
		.a         (eff_a),
		.b         (eff_b),
		.carry_in  (carry_in),
		.sum       (sum),
		.carry_out (carry_out)
	);

	result_stage u_result (
		.clk         (clk),
		.reset       (reset),
		.stage_valid (stage_valid),
		.sum         (sum),
		.carry_out   (carry_out),
		.sign_a      (sign_a),
		.sign_b      (sign_b),
		.out_valid   (out_valid),
		.result      (result),
		.accumulator (accumulator)
	);

endmodule

// File: tb/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 40 ns period
	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 3;

	initial begin
		clk = 1'b0;
		forever begin
			#(HALF_PERIOD) clk = ~clk;
		end
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: tb/adder_unit_tb.sv
// Adder unit testbench
`timescale 1ns/100ps
`include "adder_macros.svh"

module adder_unit_tb
	import adder_op_pkg::*;
	import adder_result_pkg::*;
();

	localparam logic [31:0] SEED = 32'h2350_75a8;
	localparam int RESULT_LATENCY = 2;
	localparam int DRAIN_CYCLES = 4;
	localparam int MAX_GAP = 3;
	localparam int TEST_COUNT = 6;
	localparam int DIRECTED_COUNT = 9 + 5 + 8 + 7 + 6;
	localparam int RANDOM_COUNT = 300;
	// Idle cycles of the latency test and reset hold of the reset test
	localparam int FIXED_IDLE = 11 + 3;
	localparam int CYCLE_LIMIT = DIRECTED_COUNT + RANDOM_COUNT * (MAX_GAP + 1) + FIXED_IDLE
		+ TEST_COUNT * (DRAIN_CYCLES + 2) + 50;
	localparam longint WORD_SPAN = longint'(1) << `ADDER_WIDTH;
	localparam longint MAX_POS = WORD_SPAN / 2 - 1;
	localparam longint MIN_NEG = -(WORD_SPAN / 2);

	logic           clk;
	logic           gen_reset;
	logic           tb_reset;
	logic           dut_reset;
	logic           in_valid;
	adder_request_t request;
	logic           out_valid;
	adder_result_t  result;
	adder_word_t    accumulator;

	adder_result_t exp_q[$];
	int            stamp_q[$];
	adder_word_t   model_acc;
	logic [31:0]   rng;
	string         current_test = "reset_init";
	int            cycle = 0;
	int            error_count = 0;
	int            test_errors = 0;
	int            test_results = 0;
	int            results_total = 0;
	int            tests_run = 0;

	assign dut_reset = gen_reset | tb_reset;

	tb_clock_gen u_clock (
		.clk   (clk),
		.reset (gen_reset)
	);

	adder_unit_top uut (
		.clk         (clk),
		.reset       (dut_reset),
		.in_valid    (in_valid),
		.request     (request),
		.out_valid   (out_valid),
		.result      (result),
		.accumulator (accumulator)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic longint as_signed(input adder_word_t w);
		if (w[`ADDER_WIDTH-1]) begin
			return longint'(w) - WORD_SPAN;
		end
		return longint'(w);
	endfunction

	// Expected result from plain integer arithmetic
	function automatic adder_result_t expected_result(input adder_opcode_t op,
		input adder_word_t a, input adder_word_t b, input adder_word_t acc);
		adder_result_t r;
		adder_word_t   opa;
		longint        ua;
		longint        ub;
		longint        full;
		longint        exact;
		opa = (op == op_acc_add || op == op_acc_sub) ? acc : a;
		ua = longint'(opa);
		ub = longint'(b);
		if (op == op_sub || op == op_acc_sub) begin
			full = ua - ub;
			// No borrow means carry out set
			r.flags.carry = (ua >= ub);
			exact = as_signed(opa) - as_signed(b);
		end else begin
			full = ua + ub;
			r.flags.carry = (full >= WORD_SPAN);
			exact = as_signed(opa) + as_signed(b);
		end
		r.sum = adder_word_t'(full);
		r.flags.overflow = (exact > MAX_POS) || (exact < MIN_NEG);
		r.flags.zero = (r.sum == '0);
		return r;
	endfunction

	task automatic check_sum(input string label, input adder_word_t expected,
		input adder_word_t actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h actual %h", label, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic check_flags(input string label, input adder_flags_t expected,
		input adder_flags_t actual);
		if (actual !== expected) begin
			$display("FAILED %s flags (cvz) expected %b actual %b", label, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_error(input string text);
		$display("ERROR: %s in test %s", text, current_test);
		error_count++;
		test_errors++;
	endtask

	task automatic compare_result();
		adder_result_t expected;
		int            stamp;
		if (exp_q.size() == 0) begin
			report_error("out_valid seen with no request outstanding");
		end else begin
			expected = exp_q.pop_front();
			test_results++;
			results_total++;
			if (stamp_q.size() == 0) begin
				report_error("result has no recorded request strobe");
			end else begin
				stamp = stamp_q.pop_front();
				if (cycle != stamp + RESULT_LATENCY) begin
					report_error($sformatf("result came %0d edges after its strobe",
						cycle - stamp));
				end
			end
			check_sum({current_test, " sum"}, expected.sum, result.sum);
			check_flags(current_test, expected.flags, result.flags);
			check_sum({current_test, " accumulator"}, expected.sum, accumulator);
		end
	endtask

	// Compare process, outputs are stable at the falling edge
	always @(negedge clk) begin
		if (out_valid) begin
			compare_result();
		end
		if (dut_reset) begin
			// Requests still in flight are dropped by the DUT
			exp_q.delete();
			stamp_q.delete();
		end else if (in_valid) begin
			stamp_q.push_back(cycle);
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("ERROR: timeout after %0d cycles in test %s", cycle, current_test);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic issue_request(input adder_opcode_t op, input adder_word_t a,
		input adder_word_t b);
		adder_request_t req;
		adder_result_t  exp;
		req.opcode = op;
		req.a = a;
		req.b = b;
		@(posedge clk);
		in_valid <= 1'b1;
		request <= req;
		exp = expected_result(op, a, b, model_acc);
		model_acc = exp.sum;
		exp_q.push_back(exp);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic random_request(input logic acc_only);
		adder_opcode_t op;
		adder_word_t   a;
		adder_word_t   b;
		rng = xorshift32(rng);
		op = adder_opcode_t'(rng[1:0]);
		if (acc_only) begin
			op = rng[0] ? op_acc_sub : op_acc_add;
		end
		rng = xorshift32(rng);
		a = rng[`ADDER_WIDTH-1:0];
		rng = xorshift32(rng);
		b = rng[`ADDER_WIDTH-1:0];
		issue_request(op, a, b);
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_errors = 0;
		test_results = 0;
		tests_run++;
	endtask

	task automatic finish_test();
		int waited;
		waited = 0;
		idle_cycles(1);
		while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			report_error($sformatf("%0d results never arrived", exp_q.size()));
			exp_q.delete();
			stamp_q.delete();
		end
		$display("test %s done, %0d results checked, %0d errors", current_test,
			test_results, test_errors);
	endtask

	initial begin
		in_valid = 1'b0;
		request = '0;
		tb_reset = 1'b0;
		model_acc = '0;
		rng = SEED;
		@(posedge clk);
		while (gen_reset) @(posedge clk);

		start_test("add_edges");
		issue_request(op_add, 22'h000000, 22'h000000);
		issue_request(op_add, 22'h3fffff, 22'h000001);
		issue_request(op_add, 22'h1fffff, 22'h000001);
		issue_request(op_add, 22'h155555, 22'h2aaaaa);
		issue_request(op_add, 22'h2aaaaa, 22'h2aaaaa);
		issue_request(op_add, 22'h155555, 22'h155555);
		issue_request(op_add, 22'h3fffff, 22'h3fffff);
		issue_request(op_add, 22'h200000, 22'h200000);
		issue_request(op_add, 22'h0f0f0f, 22'h30f0f1);
		finish_test();

		start_test("subtract");
		issue_request(op_sub, 22'h123456, 22'h123456);
		issue_request(op_sub, 22'h000010, 22'h000020);
		issue_request(op_sub, 22'h200000, 22'h000001);
		issue_request(op_sub, 22'h000000, 22'h000000);
		issue_request(op_sub, 22'h3fffff, 22'h000000);
		finish_test();

		// Each request depends on the one issued just before it
		start_test("acc_chain");
		issue_request(op_acc_add, 22'h000000, 22'h012345);
		issue_request(op_acc_add, 22'h000000, 22'h3f0000);
		issue_request(op_acc_sub, 22'h000000, 22'h00ffff);
		issue_request(op_acc_sub, 22'h000000, 22'h1fffff);
		issue_request(op_acc_add, 22'h000000, 22'h2aaaaa);
		issue_request(op_acc_add, 22'h000000, 22'h155555);
		issue_request(op_acc_sub, 22'h000000, 22'h000001);
		issue_request(op_acc_add, 22'h000000, 22'h000001);
		finish_test();

		start_test("random_mix");
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			random_request(1'b0);
			rng = xorshift32(rng);
			idle_cycles(int'(rng[1:0]));
		end
		finish_test();

		start_test("mid_reset");
		repeat (4) random_request(1'b1);
		@(posedge clk);
		in_valid <= 1'b0;
		tb_reset <= 1'b1;
		model_acc = '0;
		idle_cycles(1);
		@(posedge clk);
		tb_reset <= 1'b0;
		// Accumulator is zero again, so this returns b
		issue_request(op_acc_add, 22'h3fffff, 22'h0abcde);
		issue_request(op_acc_add, 22'h000000, 22'h001234);
		issue_request(op_add, 22'h000111, 22'h000222);
		finish_test();

		start_test("latency");
		issue_request(op_add, 22'h000003, 22'h000004);
		idle_cycles(5);
		issue_request(op_sub, 22'h000100, 22'h000001);
		issue_request(op_acc_add, 22'h000000, 22'h000010);
		idle_cycles(1);
		issue_request(op_acc_sub, 22'h000000, 22'h000020);
		idle_cycles(2);
		issue_request(op_add, 22'h100000, 22'h100000);
		idle_cycles(3);
		issue_request(op_acc_add, 22'h000000, 22'h3ffff0);
		finish_test();

		$display("%0d tests, %0d results checked, %0d errors", tests_run, results_total,
			error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+common
common/adder_op_pkg.sv
common/adder_result_pkg.sv
hw/prefix_adder/ling_prefix_adder.sv
hw/operand_stage.sv
hw/result_stage.sv
hw/adder_unit_top.sv
tb/tb_clock_gen.sv
tb/adder_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f verilog.f --top-module adder_unit_tb -o adder_unit_sim

output=$(./obj_dir/adder_unit_sim)
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
